// File: test/fetch_stim.txt
# W word | R target | E pc instruction compressed name
# 32-bit stream, PC steps by 4
W 00500093
E 00000000 00500093 0 addi_full
W 002081b3
E 00000004 002081b3 0 add_full
W 0000a203
E 00000008 0000a203 0 lw_full
# Two compressed parcels per word
W c1a84044
E 0000000c 00442483 1 c_lw
E 0000000e 04a5a023 1 c_sw
W 12fd52f5
E 00000010 ffd00293 1 c_li_neg
E 00000012 fff28293 1 c_addi_neg
W 850d98c1
E 00000014 ff04f493 1 c_andi_neg
E 00000016 40355513 1 c_srai
W 831e8c05
E 00000018 40940433 1 c_sub
E 0000001a 00700333 1 c_mv
# 32-bit instruction split across two words
W 0093908a
W 01920050
E 0000001c 002080b3 1 c_add
E 0000001e 00500093 0 split_full
E 00000022 00419193 1 c_slli
# Unsupported parcel then C.LUI
W 63850000
E 00000024 00000000 1 illegal
E 00000026 000013b7 1 c_lui
# Dangling half of a 32-bit instruction is flushed
W 009352f5
E 00000028 ffd00293 1 c_li_before
R 00000102
W 831effff
E 00000102 00700333 1 c_mv_target
W 00500093
E 00000104 00500093 0 full_after

// File: filelist.f
logic/common.sv
logic/rv_isa.sv
logic/compressed.sv
logic/fetch_align.sv
logic/fetch_frontend.sv
test/fetch_frontend_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FLAGS     ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o sim_$(TOP) -f filelist.f
	@output="$$(./$(OBJ_DIR)/sim_$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: test/fetch_frontend_tb.sv
module fetch_frontend_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic           clk;
    logic           rst;
    common::instr_t mem_word;
    logic           mem_valid;
    logic           redirect;
    common::addr_t  target;
    logic           fetch_hold;
    logic           instr_valid;
    common::instr_t instr;
    common::addr_t  instr_pc;
    logic           is_compressed;

    logic [7:0]     cmd_kind[$];     // "W" or "R"
    logic [31:0]    cmd_value[$];
    logic [31:0]    exp_pc[$];
    logic [31:0]    exp_instr[$];
    logic [31:0]    exp_comp[$];
    logic [127:0]   exp_name[$];

    integer         seed = 32'h3ca7_427a;
    integer         records = 0;
    integer         cycle_limit = 100;
    integer         cycles = 0;
    integer         passed = 0;
    integer         failed = 0;
    integer         mismatches;
    integer         stray = 0;
    logic           stim_loaded = 1'b0;

    fetch_frontend u_dut (
        .clk           (clk),
        .rst           (rst),
        .mem_word      (mem_word),
        .mem_valid     (mem_valid),
        .redirect      (redirect),
        .target        (target),
        .fetch_hold    (fetch_hold),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .is_compressed (is_compressed)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #5 clk = ~clk;

    task automatic compare_value(input logic [255:0] name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("ERR %0s: expected %h, actual %h", name, expected, actual);
            mismatches = mismatches + 1;
        end
    endtask

    task automatic close_record(input logic [127:0] name);
        if (mismatches == 0)
        begin
            $display("ok       %0s", name);
            passed = passed + 1;
        end
        else
        begin
            $display("mismatch %0s", name);
            failed = failed + 1;
        end
    endtask

    task automatic load_stimulus();
        integer       fd;
        integer       code;
        logic [7:0]   kind;
        logic [31:0]  value;
        logic [31:0]  ins;
        logic [31:0]  comp;
        logic [127:0] name;
        logic [1023:0] rest;
        fd = $fopen("test/fetch_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file test/fetch_stim.txt");
        end
        else
        begin
            while (!$feof(fd))
            begin
                code = $fscanf(fd, "%s", kind);
                if (code == 1)
                begin
                    if (kind == "#")
                        code = $fgets(rest, fd);    // Comment line
                    else if (kind == "E")
                    begin
                        code = $fscanf(fd, "%h %h %d %s", value, ins, comp, name);
                        exp_pc.push_back(value);
                        exp_instr.push_back(ins);
                        exp_comp.push_back(comp);
                        exp_name.push_back(name);
                        records = records + 1;
                    end
                    else
                    begin
                        code = $fscanf(fd, "%h", value);
                        cmd_kind.push_back(kind);
                        cmd_value.push_back(value);
                        records = records + 1;
                    end
                end
            end
            $fclose(fd);
            cycle_limit = 4 * records + 100;
            stim_loaded = 1'b1;
        end
    endtask

    // Only strobe once hold is seen low in a cycle with no word in flight
    task automatic send_word(input logic [31:0] word);
        integer idle;
        idle = $unsigned($random(seed)) % 3;
        repeat (idle) @(posedge clk);
        @(negedge clk);
        while (fetch_hold)
            @(negedge clk);
        @(posedge clk);
        mem_word  <= word;
        mem_valid <= 1'b1;
        @(posedge clk);
        mem_valid <= 1'b0;
    endtask

    task automatic send_redirect(input logic [31:0] addr);
        repeat (4) @(posedge clk);    // Let complete parcels drain
        @(posedge clk);
        redirect <= 1'b1;
        target   <= addr;
        @(posedge clk);
        redirect <= 1'b0;
    endtask

    always @(negedge clk)
    begin
        if (!rst && instr_valid)
        begin
            if (exp_pc.size() == 0)
            begin
                $display("Unexpected instruction %h at pc %h with nothing expected",
                         instr, instr_pc);
                stray = stray + 1;
            end
            else
            begin
                mismatches = 0;
                compare_value({exp_name[0], " pc"}, exp_pc[0], instr_pc);
                compare_value({exp_name[0], " instr"}, exp_instr[0], instr);
                compare_value({exp_name[0], " compressed"}, exp_comp[0],
                              {31'b0, is_compressed});
                close_record(exp_name[0]);
                void'(exp_pc.pop_front());
                void'(exp_instr.pop_front());
                void'(exp_comp.pop_front());
                void'(exp_name.pop_front());
            end
        end
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("Timeout after %0d cycles, expected instructions never appeared", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial
    begin
        rst       = 1'b1;
        mem_word  = '0;
        mem_valid = 1'b0;
        redirect  = 1'b0;
        target    = '0;
        load_stimulus();
        if (!stim_loaded)
        begin
            $display("Simulation finished: FAIL");
            $finish;
        end
        else
        begin
            repeat (4) @(posedge clk);
            @(negedge clk);
            mismatches = 0;    // Idle outputs while in reset
            compare_value("reset fetch_hold", 32'd0, {31'b0, fetch_hold});
            compare_value("reset instr_valid", 32'd0, {31'b0, instr_valid});
            close_record("reset");
            @(posedge clk);
            rst <= 1'b0;
            while (cmd_kind.size() != 0)
            begin
                if (cmd_kind[0] == "W")
                    send_word(cmd_value[0]);
                else
                    send_redirect(cmd_value[0]);
                void'(cmd_kind.pop_front());
                void'(cmd_value.pop_front());
            end
            while (exp_pc.size() != 0)
                @(posedge clk);
            repeat (10) @(posedge clk);    // Catch any extra output
            $display("Records checked %0d, passed %0d, failed %0d, unexpected %0d",
                     passed + failed, passed, failed, stray);
            if (failed == 0 && stray == 0)
                $display("Simulation finished: PASS");
            else
                $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

// File: logic/fetch_frontend.sv
module fetch_frontend (
    input  logic           clk,
    input  logic           rst,
    input  common::instr_t mem_word,
    input  logic           mem_valid,
    input  logic           redirect,
    input  common::addr_t  target,
    output logic           fetch_hold,
    output logic           instr_valid,
    output common::instr_t instr,
    output common::addr_t  instr_pc,
    output logic           is_compressed
);

    common::instr_t parcel_window;    // Registered slot from the aligner

    fetch_align u_align (
        .clk        (clk),
        .rst        (rst),
        .mem_word   (mem_word),
        .mem_valid  (mem_valid),
        .redirect   (redirect),
        .target     (target),
        .fetch_hold (fetch_hold),
        .out_valid  (instr_valid),
        .out_window (parcel_window),
        .out_pc     (instr_pc)
    );

    compressed u_expand (
        .mem_instruction (parcel_window),
        .is_compressed   (is_compressed),
        .instruction     (instr)
    );

endmodule

// File: logic/fetch_align.sv
module fetch_align (
    input  logic           clk,
    input  logic           rst,
    input  common::instr_t mem_word,
    input  logic           mem_valid,
    input  logic           redirect,
    input  common::addr_t  target,
    output logic           fetch_hold,
    output logic           out_valid,
    output common::instr_t out_window,
    output common::addr_t  out_pc
);

    common::parcel_t [common::BUF_HALFWORDS-1:0] buf_q;      // Entry 0 is the oldest halfword
    common::parcel_t [common::BUF_HALFWORDS-1:0] buf_d;
    common::parcel_t [common::BUF_HALFWORDS-1:0] shifted;
    common::parcel_t   word_lo;
    common::parcel_t   word_hi;
    common::hw_count_t count_q;
    common::hw_count_t pop_hw;
    common::hw_count_t remain;
    common::hw_count_t push_hw;
    common::addr_t     buf_pc_q;                              // PC of entry 0
    logic              skip_q;
    logic              lo_full;
    logic              pop;
    logic              accept;

    assign word_lo = mem_word[common::PARCEL_WIDTH-1:0];
    assign word_hi = mem_word[common::INSTRUCTION_WIDTH-1:common::PARCEL_WIDTH];

    assign lo_full = (buf_q[0][1:0] == 2'b11);                // Head needs two halfwords
    assign pop     = (count_q >= 2'd2) || (count_q == 2'd1 && !lo_full);
    assign pop_hw  = !pop ? 2'd0 : (lo_full ? 2'd2 : 2'd1);
    assign remain  = count_q - pop_hw;

    assign fetch_hold = (remain >= 2'd2);
    assign accept     = mem_valid && !fetch_hold && !redirect;
    assign push_hw    = !accept ? 2'd0 : (skip_q ? 2'd1 : 2'd2);

    assign shifted = buf_q >> (pop_hw * common::PARCEL_WIDTH);

    // New halfwords land right behind what survives the pop
    always_comb
    begin
        buf_d = shifted;
        if (push_hw == 2'd2)
        begin
            buf_d[remain]        = word_lo;
            buf_d[remain + 1'b1] = word_hi;
        end
        else if (push_hw == 2'd1)
        begin
            buf_d[remain] = word_hi;                           // Low half lies before the target
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count_q   <= '0;
            buf_pc_q  <= common::RESET_PC;
            skip_q    <= common::RESET_PC[1];
            out_valid <= 1'b0;
        end
        else if (redirect)
        begin
            count_q   <= '0;                                   // Flush buffered parcels
            buf_pc_q  <= target;
            skip_q    <= target[1];
            out_valid <= 1'b0;
        end
        else
        begin
            count_q   <= remain + push_hw;
            out_valid <= pop;
            if (pop)
            begin
                buf_pc_q <= buf_pc_q + (lo_full ? common::addr_t'(4) : common::addr_t'(2));
            end
            if (accept)
            begin
                skip_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        buf_q <= buf_d;
        if (pop)
        begin
            out_window <= buf_q[1:0];                          // Parcel plus the next halfword
            out_pc     <= buf_pc_q;
        end
    end

    a_no_word_on_hold: assert property (@(posedge clk) disable iff (rst)
        !(mem_valid && fetch_hold))
        else $error("fetch_align: word strobed while fetch_hold is high");

    // Next fill level before it is cut to the count width
    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        ({1'b0, remain} + {1'b0, push_hw}) <= common::BUF_HALFWORDS)
        else $error("fetch_align: buffer overflow, %0d halfwords",
                    {1'b0, remain} + {1'b0, push_hw});

    a_pc_even: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> !out_pc[0])
        else $error("fetch_align: odd out_pc %h", out_pc);

endmodule

// File: logic/compressed.sv
module compressed (
    input  common::instr_t mem_instruction,
    output logic           is_compressed,
    output common::instr_t instruction
);

    common::parcel_t c;
    logic [2:0]      funct3;
    logic [4:0]      rd;             // Full register fields of CR and CI forms
    logic [4:0]      rs2;
    logic [4:0]      reg_hi_p;       // Bits 9:7 mapped to x8..x15
    logic [4:0]      reg_lo_p;       // Bits 4:2 mapped to x8..x15
    logic [11:0]     imm6_sext;
    logic [19:0]     lui_imm;
    logic [11:0]     word_offset;
    logic [5:0]      shamt;

    assign c           = mem_instruction[common::PARCEL_WIDTH-1:0];
    assign funct3      = c[15:13];
    assign rd          = c[11:7];
    assign rs2         = c[6:2];
    assign reg_hi_p    = {2'b01, c[9:7]};
    assign reg_lo_p    = {2'b01, c[4:2]};
    assign imm6_sext   = {{6{c[12]}}, c[12], c[6:2]};
    assign lui_imm     = {{14{c[12]}}, c[12], c[6:2]};
    assign word_offset = {5'b0, c[5], c[12:10], c[6], 2'b00};    // Zero-extended, scaled by 4
    assign shamt       = {c[12], c[6:2]};

    assign is_compressed = (mem_instruction[1:0] != rv_isa::Q_FULL);

    always_comb
    begin
        instruction = rv_isa::ILLEGAL_INSTR;
        case (mem_instruction[1:0])
            rv_isa::Q0:
            begin
                case (funct3)
                    rv_isa::C_LW:    // rd' sits in bits 4:2
                        instruction = {word_offset, reg_hi_p, rv_isa::F3_W, reg_lo_p,
                                       rv_isa::OP_LOAD};
                    rv_isa::C_SW:
                        instruction = {word_offset[11:5], reg_lo_p, reg_hi_p, rv_isa::F3_W,
                                       word_offset[4:0], rv_isa::OP_STORE};
                    default:
                        instruction = rv_isa::ILLEGAL_INSTR;
                endcase
            end
            rv_isa::Q1:
            begin
                case (funct3)
                    rv_isa::C_ADDI:
                        instruction = {imm6_sext, rd, rv_isa::F3_ADD, rd, rv_isa::OP_IMM};
                    rv_isa::C_LI:
                        instruction = {imm6_sext, 5'd0, rv_isa::F3_ADD, rd, rv_isa::OP_IMM};
                    rv_isa::C_LUI:
                    begin
                        if (rd != 5'd2 && lui_imm != '0)    // rd = x2 is C.ADDI16SP
                            instruction = {lui_imm, rd, rv_isa::OP_LUI};
                    end
                    rv_isa::C_MISC_ALU:
                    begin
                        case (c[11:10])
                            2'b00:
                            begin
                                if (!shamt[5])    // shamt[5] set is not RV32
                                    instruction = {7'b0, shamt[4:0], reg_hi_p, rv_isa::F3_SR,
                                                   reg_hi_p, rv_isa::OP_IMM};
                            end
                            2'b01:
                            begin
                                if (!shamt[5])
                                    instruction = {rv_isa::F7_ALT, shamt[4:0], reg_hi_p,
                                                   rv_isa::F3_SR, reg_hi_p, rv_isa::OP_IMM};
                            end
                            2'b10:
                                instruction = {imm6_sext, reg_hi_p, rv_isa::F3_AND, reg_hi_p,
                                               rv_isa::OP_IMM};
                            default:
                            begin
                                if (!c[12])    // SUBW and ADDW are RV64 only
                                begin
                                    case (c[6:5])
                                        2'b00:
                                            instruction = {rv_isa::F7_ALT, reg_lo_p, reg_hi_p,
                                                           rv_isa::F3_ADD, reg_hi_p,
                                                           rv_isa::OP_REG};
                                        2'b01:
                                            instruction = {7'b0, reg_lo_p, reg_hi_p,
                                                           rv_isa::F3_XOR, reg_hi_p,
                                                           rv_isa::OP_REG};
                                        2'b10:
                                            instruction = {7'b0, reg_lo_p, reg_hi_p,
                                                           rv_isa::F3_OR, reg_hi_p,
                                                           rv_isa::OP_REG};
                                        default:
                                            instruction = {7'b0, reg_lo_p, reg_hi_p,
                                                           rv_isa::F3_AND, reg_hi_p,
                                                           rv_isa::OP_REG};
                                    endcase
                                end
                            end
                        endcase
                    end
                    default:
                        instruction = rv_isa::ILLEGAL_INSTR;
                endcase
            end
            rv_isa::Q2:
            begin
                case (funct3)
                    rv_isa::C_SLLI:
                    begin
                        if (!shamt[5])
                            instruction = {7'b0, shamt[4:0], rd, rv_isa::F3_SLL, rd,
                                           rv_isa::OP_IMM};
                    end
                    rv_isa::C_CR:
                    begin
                        if (rs2 != 5'd0 && c[12])    // C.ADD
                            instruction = {7'b0, rs2, rd, rv_isa::F3_ADD, rd, rv_isa::OP_REG};
                        else if (rs2 != 5'd0)        // C.MV, add from x0
                            instruction = {7'b0, rs2, 5'd0, rv_isa::F3_ADD, rd, rv_isa::OP_REG};
                    end
                    default:
                        instruction = rv_isa::ILLEGAL_INSTR;
                endcase
            end
            default:
                instruction = mem_instruction;
        endcase
    end

endmodule

// File: logic/rv_isa.sv
package rv_isa;

    // RV32I major opcodes
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;

    localparam logic [2:0] F3_ADD = 3'b000;    // Also SUB and ADDI
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SR  = 3'b101;    // SRL and SRA
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_W   = 3'b010;    // Word load and store

    localparam logic [6:0] F7_ALT = 7'b0100000;

    // Low two bits of a parcel
    localparam logic [1:0] Q0     = 2'b00;
    localparam logic [1:0] Q1     = 2'b01;
    localparam logic [1:0] Q2     = 2'b10;
    localparam logic [1:0] Q_FULL = 2'b11;

    localparam logic [2:0] C_LW       = 3'b010;    // Quadrant 0
    localparam logic [2:0] C_SW       = 3'b110;
    localparam logic [2:0] C_ADDI     = 3'b000;    // Quadrant 1
    localparam logic [2:0] C_LI       = 3'b010;
    localparam logic [2:0] C_LUI      = 3'b011;
    localparam logic [2:0] C_MISC_ALU = 3'b100;
    localparam logic [2:0] C_SLLI     = 3'b000;    // Quadrant 2
    localparam logic [2:0] C_CR       = 3'b100;    // MV, ADD and the jumps

    localparam common::instr_t ILLEGAL_INSTR = '0;

endpackage

// File: logic/common.sv
package common;

    localparam int INSTRUCTION_WIDTH = 32;
    localparam int PARCEL_WIDTH      = 16;
    localparam int XLEN              = 32;
    localparam int BUF_HALFWORDS     = 3;    // Two buffered plus one spare for a split word

    typedef logic [INSTRUCTION_WIDTH-1:0] instr_t;
    typedef logic [PARCEL_WIDTH-1:0]      parcel_t;
    typedef logic [XLEN-1:0]              addr_t;
    typedef logic [1:0]                   hw_count_t;    // Halfwords held in the aligner

    localparam addr_t RESET_PC = 32'h0000_0000;

endpackage
